// ==== common/vred_pkg.sv ====
`default_nettype none

package vred_pkg;

    localparam int VREG_W = 128;
    localparam int XLEN   = 32;
    localparam int HALF_W = 2 * VREG_W;

    typedef logic [VREG_W-1:0] vreg_t;
    typedef logic [HALF_W-1:0] half_t;   // also the fold accumulator
    typedef logic [XLEN-1:0]   xword_t;

    typedef enum logic {
        RED_SUM = 1'b0,
        RED_MAX = 1'b1
    } red_op_e;

    typedef enum logic [1:0] {
        SEW8  = 2'd0,
        SEW16 = 2'd1,
        SEW32 = 2'd2     // code 3 decodes as 32 too
    } sew_e;

    typedef enum logic [1:0] {
        LMUL1 = 2'd0,
        LMUL2 = 2'd1,
        LMUL4 = 2'd2     // code 3 decodes as 4 too
    } lmul_e;

    // pair-fold steps to bring one 256-bit half down to a single element
    function automatic logic [2:0] fold_steps(sew_e s);
        case (s)
            SEW8:    return 3'd5;
            SEW16:   return 3'd4;
            default: return 3'd3;
        endcase
    endfunction

    function automatic int reg_count(lmul_e l);
        case (l)
            LMUL1:   return 1;
            LMUL2:   return 2;
            default: return 4;
        endcase
    endfunction

    function automatic logic signed [XLEN-1:0] elem_sext(xword_t x, sew_e s);
        case (s)
            SEW8:    return {{24{x[7]}}, x[7:0]};
            SEW16:   return {{16{x[15]}}, x[15:0]};
            default: return x;
        endcase
    endfunction

    function automatic xword_t elem_zext(xword_t x, sew_e s);
        case (s)
            SEW8:    return {24'b0, x[7:0]};
            SEW16:   return {16'b0, x[15:0]};
            default: return x;
        endcase
    endfunction

    // a wins ties on max, sum wraps at the element width once truncated
    function automatic xword_t red_apply(red_op_e o, sew_e s, xword_t a, xword_t b);
        if (o == RED_MAX)
            return (elem_sext(a, s) >= elem_sext(b, s)) ? a : b;
        return a + b;
    endfunction

endpackage

`default_nettype wire

// ==== logic/fold_unit.sv ====
`default_nettype none

module fold_unit #(
    parameter int FIRST_REG = 0
) (
    input  wire                 clk,
    input  wire                 nrst,
    input  wire                 start,
    input  wire vred_pkg::red_op_e op,
    input  wire vred_pkg::sew_e    sew,
    input  wire vred_pkg::lmul_e   lmul,
    input  wire vred_pkg::vreg_t   reg_lo,
    input  wire vred_pkg::vreg_t   reg_hi,
    output logic                fold_done,
    output vred_pkg::xword_t    half_result
);

    import vred_pkg::*;

    typedef enum logic {
        ST_IDLE,
        ST_FOLD
    } state_e;

    state_e     state;
    red_op_e    op_q;
    sew_e       sew_q;
    logic [2:0] step;
    half_t      acc;
    vreg_t      lo_load;
    vreg_t      hi_load;
    logic       accept;

    // every element set to the neutral value of the operation
    function automatic vreg_t ident_vreg(red_op_e o, sew_e s);
        if (o == RED_SUM)
            return '0;
        case (s)
            SEW8:    return {(VREG_W / 8){8'h80}};
            SEW16:   return {(VREG_W / 16){16'h8000}};
            default: return {(VREG_W / 32){32'h8000_0000}};
        endcase
    endfunction

    // element i of the result is built from elements 2i and 2i+1
    function automatic half_t fold_pairs(half_t v, red_op_e o, sew_e s);
        half_t  r;
        xword_t t;
        r = v;
        case (s)
            SEW8:
                for (int i = 0; i < HALF_W / 16; i++)
                begin
                    t = red_apply(o, s, XLEN'(v[16*i +: 8]), XLEN'(v[16*i+8 +: 8]));
                    r[8*i +: 8] = t[7:0];
                end
            SEW16:
                for (int i = 0; i < HALF_W / 32; i++)
                begin
                    t = red_apply(o, s, XLEN'(v[32*i +: 16]), XLEN'(v[32*i+16 +: 16]));
                    r[16*i +: 16] = t[15:0];
                end
            default:
                for (int i = 0; i < HALF_W / 64; i++)
                begin
                    t = red_apply(o, s, v[64*i +: 32], v[64*i+32 +: 32]);
                    r[32*i +: 32] = t;
                end
        endcase
        return r;
    endfunction

    assign accept = (state == ST_IDLE) && start;

    // registers outside the lmul group are swapped for the identity
    assign lo_load = (FIRST_REG < reg_count(lmul)) ? reg_lo : ident_vreg(op, sew);
    assign hi_load = (FIRST_REG + 1 < reg_count(lmul)) ? reg_hi : ident_vreg(op, sew);

    always_ff @(posedge clk)
    begin
        if (!nrst)
        begin
            state     <= ST_IDLE;
            step      <= '0;
            fold_done <= 1'b0;
        end
        else
        begin
            fold_done <= 1'b0;
            case (state)
                ST_IDLE:
                    if (start)
                    begin
                        state <= ST_FOLD;
                        step  <= '0;
                    end
                default:
                begin
                    step <= step + 3'd1;
                    if (step + 3'd1 == fold_steps(sew_q))   // last fold
                    begin
                        state     <= ST_IDLE;
                        fold_done <= 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            acc   <= {hi_load, lo_load};
            op_q  <= op;
            sew_q <= sew;
        end
        else if (state == ST_FOLD)
        begin
            acc <= fold_pairs(acc, op_q, sew_q);
        end
    end

    assign half_result = elem_zext(acc[XLEN-1:0], sew_q);   // element 0 after the last fold

    step_bound: assert property (@(posedge clk) disable iff (!nrst)
        step <= fold_steps(sew_q));

    sew_known: assert property (@(posedge clk) disable iff (!nrst)
        start |-> !$isunknown(sew));

endmodule

`default_nettype wire

// ==== logic/red_combine.sv ====
`default_nettype none

module red_combine (
    input  wire                    clk,
    input  wire                    nrst,
    input  wire                    start,
    input  wire                    lo_done,
    input  wire                    hi_done,
    input  wire vred_pkg::red_op_e op,
    input  wire vred_pkg::sew_e    sew,
    input  wire vred_pkg::xword_t  lo_result,
    input  wire vred_pkg::xword_t  hi_result,
    input  wire vred_pkg::xword_t  scalar,
    output logic                   done,
    output vred_pkg::xword_t       result
);

    import vred_pkg::*;

    logic    busy;
    logic    accept;
    red_op_e op_q;
    sew_e    sew_q;
    xword_t  scalar_q;
    xword_t  half_merged;
    xword_t  merged;

    // a new start may land on the same edge that retires the current one
    assign accept = start && (!busy || lo_done);

    assign half_merged = red_apply(op_q, sew_q, lo_result, hi_result);
    assign merged      = elem_zext(red_apply(op_q, sew_q, scalar_q, half_merged), sew_q);   // scalar keeps ties

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            op_q     <= op;
            sew_q    <= sew;
            scalar_q <= scalar;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!nrst)
        begin
            busy   <= 1'b0;
            done   <= 1'b0;
            result <= '0;
        end
        else
        begin
            done <= lo_done;
            if (lo_done)
                result <= merged;   // held until the next done
            if (accept)
                busy <= 1'b1;
            else if (lo_done)
                busy <= 1'b0;
        end
    end

    halves_agree: assert property (@(posedge clk) disable iff (!nrst)
        lo_done == hi_done);

    done_pulse: assert property (@(posedge clk) disable iff (!nrst)
        done |=> !done);

endmodule

`default_nettype wire

// ==== logic/vec_reduce.sv ====
`default_nettype none

module vec_reduce (
    input  wire                    clk,
    input  wire                    nrst,
    input  wire                    start,
    input  wire vred_pkg::red_op_e op,
    input  wire vred_pkg::sew_e    sew,
    input  wire vred_pkg::lmul_e   lmul,
    input  wire vred_pkg::vreg_t   vreg1,
    input  wire vred_pkg::vreg_t   vreg2,
    input  wire vred_pkg::vreg_t   vreg3,
    input  wire vred_pkg::vreg_t   vreg4,
    input  wire vred_pkg::xword_t  scalar,
    output logic                   done,
    output vred_pkg::xword_t       result
);

    import vred_pkg::*;

    logic   lo_done;
    logic   hi_done;
    xword_t lo_result;
    xword_t hi_result;

    // registers 0 and 1 of the group
    fold_unit #(
        .FIRST_REG (0)
    ) u_fold_lo (
        .clk         (clk),
        .nrst        (nrst),
        .start       (start),
        .op          (op),
        .sew         (sew),
        .lmul        (lmul),
        .reg_lo      (vreg1),
        .reg_hi      (vreg2),
        .fold_done   (lo_done),
        .half_result (lo_result)
    );

    // registers 2 and 3, only live for lmul 4
    fold_unit #(
        .FIRST_REG (2)
    ) u_fold_hi (
        .clk         (clk),
        .nrst        (nrst),
        .start       (start),
        .op          (op),
        .sew         (sew),
        .lmul        (lmul),
        .reg_lo      (vreg3),
        .reg_hi      (vreg4),
        .fold_done   (hi_done),
        .half_result (hi_result)
    );

    red_combine u_combine (
        .clk       (clk),
        .nrst      (nrst),
        .start     (start),
        .lo_done   (lo_done),
        .hi_done   (hi_done),
        .op        (op),
        .sew       (sew),
        .lo_result (lo_result),
        .hi_result (hi_result),
        .scalar    (scalar),
        .done      (done),
        .result    (result)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_vec_reduce.sv ====
`default_nettype none

module tb_vec_reduce;

    timeunit 1ns;
    timeprecision 1ps;

    import vred_pkg::*;

    localparam int RESET_CYCLES    = 16;
    localparam int NUM_CASES       = 48;
    localparam int DONE_LIMIT      = 20;   // cycles allowed between start and done
    localparam int WATCHDOG_CYCLES = NUM_CASES * 10 + 2 * RESET_CYCLES;

    // row layout mode_op_sew_lmul
    // mode 0 random, 1 all negative, 2 inactive regs all ones, 3 second start while busy
    localparam logic [6:0] CASE_TAB [NUM_CASES] = '{
        7'b00_0_00_00, 7'b00_0_00_01, 7'b00_0_00_10, 7'b00_0_00_11,
        7'b00_0_01_00, 7'b00_0_01_01, 7'b00_0_01_10, 7'b00_0_01_11,
        7'b00_0_10_00, 7'b00_0_10_01, 7'b00_0_10_10, 7'b00_0_10_11,
        7'b00_0_11_00, 7'b00_0_11_01, 7'b00_0_11_10, 7'b00_0_11_11,
        7'b01_1_00_00, 7'b01_1_00_01, 7'b01_1_00_10, 7'b01_1_00_11,
        7'b01_1_01_00, 7'b01_1_01_01, 7'b01_1_01_10, 7'b01_1_01_11,
        7'b01_1_10_00, 7'b01_1_10_01, 7'b01_1_10_10, 7'b01_1_10_11,
        7'b01_1_11_00, 7'b01_1_11_01, 7'b01_1_11_10, 7'b01_1_11_11,
        7'b00_1_00_00, 7'b00_1_01_01, 7'b00_1_10_10, 7'b00_1_11_11,
        7'b10_0_00_00, 7'b10_0_01_01, 7'b10_0_10_00, 7'b10_0_11_01,
        7'b10_1_00_01, 7'b10_1_01_00, 7'b10_1_10_01, 7'b10_1_11_00,
        7'b11_0_00_10, 7'b11_1_10_01, 7'b11_1_01_11, 7'b11_0_11_00
    };

    logic     clk;
    logic     nrst;
    logic     start;
    red_op_e  op;
    sew_e     sew;
    lmul_e    lmul;
    vreg_t    vreg1;
    vreg_t    vreg2;
    vreg_t    vreg3;
    vreg_t    vreg4;
    xword_t   scalar;
    logic     done;
    xword_t   result;

    logic [31:0] lfsr_state;
    xword_t      last_result;
    int          value_errors;
    int          handshake_errors;

    vec_reduce dut (
        .clk    (clk),
        .nrst   (nrst),
        .start  (start),
        .op     (op),
        .sew    (sew),
        .lmul   (lmul),
        .vreg1  (vreg1),
        .vreg2  (vreg2),
        .vreg3  (vreg3),
        .vreg4  (vreg4),
        .scalar (scalar),
        .done   (done),
        .result (result)
    );

    always #2 clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_bits(input int n, output logic [31:0] w);
        w = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            w = {w[30:0], lfsr_state[0]};
        end
    endtask

    task automatic fill_vreg(output vreg_t v);
        logic [31:0] w;
        for (int k = 0; k < 4; k++)
        begin
            random_bits(32, w);
            v[32*k +: 32] = w;
        end
    endtask

    function automatic vreg_t sign_bits(input logic [1:0] sew_code);
        case (sew_code)
            2'd0:    return {16{8'h80}};
            2'd1:    return {8{16'h8000}};
            default: return {4{32'h8000_0000}};
        endcase
    endfunction

    function automatic longint as_signed(input logic [31:0] x, input int w);
        if (x[w-1])
            return longint'(x) - (longint'(1) << w);
        return longint'(x);
    endfunction

    // sum wraps at the element width, max is signed, scalar counts as one more element
    function automatic xword_t expected_result(input logic is_max, input logic [1:0] sew_code,
            input logic [1:0] lmul_code, input logic [511:0] group, input xword_t scal);
        int          w;
        int          count;
        logic [31:0] mask;
        logic [31:0] e;
        logic [31:0] sum;
        longint      best;
        w = (sew_code == 2'd0) ? 8 : (sew_code == 2'd1) ? 16 : 32;
        count = ((lmul_code == 2'd0) ? 1 : (lmul_code == 2'd1) ? 2 : 4) * 128 / w;
        mask = (w == 32) ? 32'hffff_ffff : ((32'd1 << w) - 32'd1);
        sum = scal & mask;
        best = as_signed(scal & mask, w);
        for (int i = 0; i < count; i++)
        begin
            e = 32'(group >> (i * w)) & mask;
            sum = sum + e;
            if (as_signed(e, w) > best)
                best = as_signed(e, w);
        end
        if (is_max)
            return 32'(best) & mask;
        return sum & mask;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            value_errors++;
            $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic check_event(input logic ok, input string what);
        assert (ok)
        else
        begin
            handshake_errors++;
            $display("%s", what);
        end
    endtask

    // inputs are free to change once start has been sampled
    task automatic scramble_inputs(input logic row_op);
        logic [31:0] w;
        op = red_op_e'(~row_op);
        random_bits(2, w);
        sew = sew_e'(w[1:0]);
        random_bits(2, w);
        lmul = lmul_e'(w[1:0]);
        fill_vreg(vreg1);
        fill_vreg(vreg2);
        fill_vreg(vreg3);
        fill_vreg(vreg4);
        random_bits(32, scalar);
    endtask

    task automatic run_case(input logic [6:0] row);
        logic [1:0] mode;
        int         nreg;
        int         latency;
        int         n;
        vreg_t      regs [4];
        vreg_t      neg;
        xword_t     scal;
        xword_t     expected;
        mode = row[6:5];
        nreg = (row[1:0] == 2'd0) ? 1 : (row[1:0] == 2'd1) ? 2 : 4;
        latency = (row[3:2] == 2'd0) ? 6 : (row[3:2] == 2'd1) ? 5 : 4;
        neg = sign_bits(row[3:2]);
        for (int r = 0; r < 4; r++)
        begin
            fill_vreg(regs[r]);
            if (mode == 2'd1 || mode == 2'd2)
                regs[r] = regs[r] | neg;
            if (mode == 2'd2 && r >= nreg)
                regs[r] = '1;   // -1 per element, beats any negative active value
        end
        random_bits(32, scal);
        if (mode == 2'd1 || mode == 2'd2)
            scal = scal | neg[31:0];
        expected = expected_result(row[4], row[3:2], row[1:0],
                                   {regs[3], regs[2], regs[1], regs[0]}, scal);
        start = 1'b1;
        op = red_op_e'(row[4]);
        sew = sew_e'(row[3:2]);
        lmul = lmul_e'(row[1:0]);
        vreg1 = regs[0];
        vreg2 = regs[1];
        vreg3 = regs[2];
        vreg4 = regs[3];
        scalar = scal;
        n = 0;
        do
        begin
            @(negedge clk);
            n++;
            if (!done)
                check_value("result", result, last_result);
            if (n == 1)
            begin
                start = 1'b0;
                scramble_inputs(row[4]);
            end
            if (mode == 2'd3)
                start = (n == 2);   // lands mid fold
        end
        while (!done && n < DONE_LIMIT);
        start = 1'b0;
        if (!done)
        begin
            check_event(1'b0, $sformatf("no done within %0d cycles of start", DONE_LIMIT));
        end
        else
        begin
            check_event(n - 1 == latency,
                $sformatf("done came %0d cycles after start instead of %0d", n - 1, latency));
            check_value("result", result, expected);
            last_result = expected;
        end
        repeat (2)
        begin
            @(negedge clk);
            check_event(!done, "done was high again after the result pulse");
            check_value("result", result, last_result);
        end
    endtask

    initial
    begin
        clk = 1'b0;
        nrst = 1'b0;
        start = 1'b0;
        op = RED_SUM;
        sew = SEW8;
        lmul = LMUL1;
        vreg1 = '0;
        vreg2 = '0;
        vreg3 = '0;
        vreg4 = '0;
        scalar = '0;
        lfsr_state = 32'hb1da;
        last_result = '0;
        value_errors = 0;
        handshake_errors = 0;
        repeat (RESET_CYCLES) @(negedge clk);
        nrst = 1'b1;
        repeat (3)
        begin
            @(negedge clk);
            check_event(!done, "done was high after reset with no start given");
            check_value("result", result, 32'h0);
        end
        for (int c = 0; c < NUM_CASES; c++)
            run_case(CASE_TAB[c]);
        $display("errors: %0d value, %0d handshake", value_errors, handshake_errors);
        if (value_errors == 0 && handshake_errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run is stuck", WATCHDOG_CYCLES);
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
common/vred_pkg.sv
logic/fold_unit.sv
logic/red_combine.sv
logic/vec_reduce.sv
testbench/tb_vec_reduce.sv

// ==== Makefile ====
# Verilator build and run of the vector reduction testbench

VERILATOR ?= verilator
TOP       ?= tb_vec_reduce
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timescale 1ns/1ps
PASS_MSG  ?= Verification passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
